// ==== pipe_settings.svh ====
`ifndef PIPE_SETTINGS_SVH
`define PIPE_SETTINGS_SVH

// datapath and register index widths
`define PIPE_XLEN 32
`define PIPE_REG_AW 5
// data memory depth in words, addresses wrap
`define PIPE_DMEM_WORDS 64

// ============================================================
// opcode field, instr[31:26]
// ============================================================
`define PIPE_OP_RTYPE 6'h00
`define PIPE_OP_ADDIU 6'h09
`define PIPE_OP_SLTI 6'h0a
`define PIPE_OP_ANDI 6'h0c
`define PIPE_OP_ORI 6'h0d
`define PIPE_OP_LB 6'h20
`define PIPE_OP_LH 6'h21
`define PIPE_OP_LW 6'h23
`define PIPE_OP_LBU 6'h24
`define PIPE_OP_LHU 6'h25
`define PIPE_OP_SB 6'h28
`define PIPE_OP_SH 6'h29
`define PIPE_OP_SW 6'h2b

// ============================================================
// funct field of r-type, instr[5:0]
// ============================================================
`define PIPE_FN_SLL 6'h00
`define PIPE_FN_SRL 6'h02
`define PIPE_FN_SRA 6'h03
`define PIPE_FN_ADDU 6'h21
`define PIPE_FN_SUBU 6'h23
`define PIPE_FN_AND 6'h24
`define PIPE_FN_OR 6'h25
`define PIPE_FN_XOR 6'h26
`define PIPE_FN_NOR 6'h27
`define PIPE_FN_SLT 6'h2a
`define PIPE_FN_SLTU 6'h2b

`endif

// ==== pipe_pkg.sv ====
`include "pipe_settings.svh"

package pipe_pkg;

	// basic word and register index
	typedef logic [`PIPE_XLEN-1:0] wordT;
	typedef logic [`PIPE_REG_AW-1:0] regIdxT;

	// alu operations, addu must stay at zero
	typedef enum logic [3:0] {
		aluAddu, aluSubu, aluAnd, aluOr, aluXor, aluNor,
		aluSlt, aluSltu, aluSll, aluSrl, aluSra
	} aluOpE;

	// memory access kind, memNone at zero
	typedef enum logic [3:0] {
		memNone, memLw, memLh, memLhu, memLb, memLbu, memSw, memSh, memSb
	} memOpE;

	typedef enum logic [1:0] {
		excNone, reservedInstr, loadAddrErr, storeAddrErr
	} excCodeE;

	// execute operand source
	typedef enum logic [1:0] {fromReg, fromMem, fromWb} fwdSelE;

	// ============================================================
	// stage payloads
	// ============================================================
	typedef struct packed {
		aluOpE aluOp;
		logic useImm;
		logic immZeroExt;
		memOpE memOp;
		logic regWrite;
		excCodeE exc;
	} ctrlBundleT;

	typedef struct packed {
		ctrlBundleT ctrl;
		regIdxT rs;
		regIdxT rt;
		regIdxT dest;
		wordT opA;
		wordT opB;
		wordT imm;
		logic [4:0] shamt;
	} exStageT;

	typedef struct packed {
		ctrlBundleT ctrl;
		regIdxT dest;
		wordT aluRes;
		wordT storeData;
	} memStageT;

	// value holds result, effective address, or zero
	typedef struct packed {
		regIdxT dest;
		wordT value;
		logic regWrite;
		excCodeE exc;
	} retireT;

	function automatic logic isLoad(memOpE op);
		return op inside {memLw, memLh, memLhu, memLb, memLbu};
	endfunction

	function automatic logic isStore(memOpE op);
		return op inside {memSw, memSh, memSb};
	endfunction

endpackage

// ==== stageReg.sv ====
`timescale 1ns/1ps

module stageReg #(
	parameter type payloadT = logic
) (
	input logic clk,
	input logic rst,
	input logic hold,
	input logic bubble,
	input logic inValid,
	input payloadT inData,
	output logic outValid,
	output payloadT outData
);

	// valid bit, bubble wins over hold
	always_ff @(posedge clk) begin
		if (rst) begin
			outValid <= 1'b0;
		end else if (bubble) begin
			outValid <= 1'b0;
		end else if (!hold) begin
			outValid <= inValid;
		end
	end

	// payload only moves when the slot advances
	always_ff @(posedge clk) begin
		if (!hold && !bubble) begin
			outData <= inData;
		end
	end

endmodule

// ==== instrDecode.sv ====
`timescale 1ns/1ps
`include "pipe_settings.svh"

module instrDecode (
	input pipe_pkg::wordT instr,
	output pipe_pkg::ctrlBundleT ctrl,
	output pipe_pkg::regIdxT rs,
	output pipe_pkg::regIdxT rt,
	output pipe_pkg::regIdxT dest,
	output pipe_pkg::wordT imm,
	output logic [4:0] shamt
);

	logic [5:0] opcode;
	logic [5:0] funct;
	logic destRd;

	// fixed mips field positions
	assign opcode = instr[31:26];
	assign funct = instr[5:0];
	assign rs = instr[25:21];
	assign rt = instr[20:16];
	assign shamt = instr[10:6];

	always_comb begin
		// zero struct is addu, no memory, no write, no fault
		ctrl = '0;
		destRd = 1'b0;
		case (opcode)
			`PIPE_OP_RTYPE: begin
				destRd = 1'b1;
				ctrl.regWrite = 1'b1;
				case (funct)
					`PIPE_FN_ADDU: ctrl.aluOp = pipe_pkg::aluAddu;
					`PIPE_FN_SUBU: ctrl.aluOp = pipe_pkg::aluSubu;
					`PIPE_FN_AND: ctrl.aluOp = pipe_pkg::aluAnd;
					`PIPE_FN_OR: ctrl.aluOp = pipe_pkg::aluOr;
					`PIPE_FN_XOR: ctrl.aluOp = pipe_pkg::aluXor;
					`PIPE_FN_NOR: ctrl.aluOp = pipe_pkg::aluNor;
					`PIPE_FN_SLT: ctrl.aluOp = pipe_pkg::aluSlt;
					`PIPE_FN_SLTU: ctrl.aluOp = pipe_pkg::aluSltu;
					`PIPE_FN_SLL: ctrl.aluOp = pipe_pkg::aluSll;
					`PIPE_FN_SRL: ctrl.aluOp = pipe_pkg::aluSrl;
					`PIPE_FN_SRA: ctrl.aluOp = pipe_pkg::aluSra;
					default: begin
						// unknown funct, no write
						ctrl.regWrite = 1'b0;
						ctrl.exc = pipe_pkg::reservedInstr;
					end
				endcase
			end
			`PIPE_OP_ADDIU: begin
				ctrl.useImm = 1'b1;
				ctrl.regWrite = 1'b1;
			end
			`PIPE_OP_SLTI: begin
				ctrl.aluOp = pipe_pkg::aluSlt;
				ctrl.useImm = 1'b1;
				ctrl.regWrite = 1'b1;
			end
			// logic immediates are zero extended
			`PIPE_OP_ANDI, `PIPE_OP_ORI: begin
				ctrl.aluOp = (opcode == `PIPE_OP_ANDI) ? pipe_pkg::aluAnd : pipe_pkg::aluOr;
				ctrl.useImm = 1'b1;
				ctrl.immZeroExt = 1'b1;
				ctrl.regWrite = 1'b1;
			end
			// loads: address is rs + signed offset
			`PIPE_OP_LW: ctrl = '{pipe_pkg::aluAddu, 1'b1, 1'b0, pipe_pkg::memLw, 1'b1,
				pipe_pkg::excNone};
			`PIPE_OP_LH: ctrl = '{pipe_pkg::aluAddu, 1'b1, 1'b0, pipe_pkg::memLh, 1'b1,
				pipe_pkg::excNone};
			`PIPE_OP_LHU: ctrl = '{pipe_pkg::aluAddu, 1'b1, 1'b0, pipe_pkg::memLhu, 1'b1,
				pipe_pkg::excNone};
			`PIPE_OP_LB: ctrl = '{pipe_pkg::aluAddu, 1'b1, 1'b0, pipe_pkg::memLb, 1'b1,
				pipe_pkg::excNone};
			`PIPE_OP_LBU: ctrl = '{pipe_pkg::aluAddu, 1'b1, 1'b0, pipe_pkg::memLbu, 1'b1,
				pipe_pkg::excNone};
			// stores never write a register
			`PIPE_OP_SW: ctrl = '{pipe_pkg::aluAddu, 1'b1, 1'b0, pipe_pkg::memSw, 1'b0,
				pipe_pkg::excNone};
			`PIPE_OP_SH: ctrl = '{pipe_pkg::aluAddu, 1'b1, 1'b0, pipe_pkg::memSh, 1'b0,
				pipe_pkg::excNone};
			`PIPE_OP_SB: ctrl = '{pipe_pkg::aluAddu, 1'b1, 1'b0, pipe_pkg::memSb, 1'b0,
				pipe_pkg::excNone};
			default: ctrl.exc = pipe_pkg::reservedInstr;
		endcase
	end

	// r-type writes rd, the rest rt
	assign dest = destRd ? instr[15:11] : rt;
	assign imm = ctrl.immZeroExt ? {{(`PIPE_XLEN-16){1'b0}}, instr[15:0]}
		: {{(`PIPE_XLEN-16){instr[15]}}, instr[15:0]};

endmodule

// ==== regFile.sv ====
`timescale 1ns/1ps
`include "pipe_settings.svh"

module regFile (
	input logic clk,
	input logic rst,
	input logic wrEn,
	input pipe_pkg::regIdxT wrAddr,
	input pipe_pkg::wordT wrData,
	input pipe_pkg::regIdxT rdAddrA,
	input pipe_pkg::regIdxT rdAddrB,
	output pipe_pkg::wordT rdDataA,
	output pipe_pkg::wordT rdDataB
);

	pipe_pkg::wordT regs [1 << `PIPE_REG_AW];

	// r0 is never stored
	always_ff @(posedge clk) begin
		if (rst) begin
			for (int i = 0; i < (1 << `PIPE_REG_AW); i++) begin
				regs[i] <= '0;
			end
		end else if (wrEn && wrAddr != '0) begin
			regs[wrAddr] <= wrData;
		end
	end

	// write-first bypass, r0 reads zero
	assign rdDataA = (rdAddrA == '0) ? '0 : (wrEn && wrAddr == rdAddrA) ? wrData : regs[rdAddrA];
	assign rdDataB = (rdAddrB == '0) ? '0 : (wrEn && wrAddr == rdAddrB) ? wrData : regs[rdAddrB];

endmodule

// ==== aluUnit.sv ====
`timescale 1ns/1ps

module aluUnit (
	input pipe_pkg::aluOpE op,
	input pipe_pkg::wordT a,
	input pipe_pkg::wordT b,
	input logic [4:0] shamt,
	output pipe_pkg::wordT result
);

	always_comb begin
		result = '0;
		case (op)
			pipe_pkg::aluAddu: result = a + b;
			pipe_pkg::aluSubu: result = a - b;
			pipe_pkg::aluAnd: result = a & b;
			pipe_pkg::aluOr: result = a | b;
			pipe_pkg::aluXor: result = a ^ b;
			pipe_pkg::aluNor: result = ~(a | b);
			// compares give 0 or 1 in bit 0
			pipe_pkg::aluSlt: result[0] = $signed(a) < $signed(b);
			pipe_pkg::aluSltu: result[0] = a < b;
			// shifts act on b, amount from the instr field
			pipe_pkg::aluSll: result = b << shamt;
			pipe_pkg::aluSrl: result = b >> shamt;
			pipe_pkg::aluSra: result = $signed(b) >>> shamt;
			default: result = '0;
		endcase
	end

endmodule

// ==== memAccess.sv ====
`timescale 1ns/1ps
`include "pipe_settings.svh"

module memAccess (
	input logic clk,
	input logic rst,
	input logic valid,
	input pipe_pkg::memOpE memOp,
	input pipe_pkg::wordT addr,
	input pipe_pkg::wordT storeData,
	output pipe_pkg::wordT loadData,
	output pipe_pkg::excCodeE alignExc
);

	localparam int IdxW = $clog2(`PIPE_DMEM_WORDS);

	pipe_pkg::wordT mem [`PIPE_DMEM_WORDS];
	logic [IdxW-1:0] wordIdx;
	logic [1:0] off;
	logic misaligned;
	logic storeEn;
	logic [3:0] byteEn;
	pipe_pkg::wordT laneData;
	pipe_pkg::wordT rdWord;
	logic [15:0] halfSel;
	logic [7:0] byteSel;

	// word index wraps with memory depth
	assign wordIdx = addr[IdxW+1:2];
	assign off = addr[1:0];

	// ============================================================
	// alignment check
	// ============================================================
	always_comb begin
		case (memOp)
			pipe_pkg::memLw, pipe_pkg::memSw: misaligned = (off != 2'b00);
			pipe_pkg::memLh, pipe_pkg::memLhu, pipe_pkg::memSh: misaligned = off[0];
			default: misaligned = 1'b0;
		endcase
		alignExc = pipe_pkg::excNone;
		if (valid && misaligned) begin
			alignExc = pipe_pkg::isLoad(memOp) ? pipe_pkg::loadAddrErr : pipe_pkg::storeAddrErr;
		end
	end

	// ============================================================
	// store lanes, little endian byte order
	// ============================================================
	always_comb begin
		case (memOp)
			pipe_pkg::memSw: begin
				byteEn = 4'b1111;
				laneData = storeData;
			end
			pipe_pkg::memSh: begin
				byteEn = off[1] ? 4'b1100 : 4'b0011;
				laneData = {2{storeData[15:0]}};
			end
			pipe_pkg::memSb: begin
				byteEn = 4'b0001 << off;
				laneData = {4{storeData[7:0]}};
			end
			default: begin
				byteEn = 4'b0000;
				laneData = storeData;
			end
		endcase
	end

	// fault suppresses the write
	assign storeEn = valid && pipe_pkg::isStore(memOp) && (alignExc == pipe_pkg::excNone);

	always_ff @(posedge clk) begin
		if (rst) begin
			for (int w = 0; w < `PIPE_DMEM_WORDS; w++) begin
				mem[w] <= '0;
			end
		end else if (storeEn) begin
			for (int b = 0; b < 4; b++) begin
				if (byteEn[b]) begin
					mem[wordIdx][8*b +: 8] <= laneData[8*b +: 8];
				end
			end
		end
	end

	// load side, combinational read and extend
	assign rdWord = mem[wordIdx];
	assign halfSel = off[1] ? rdWord[31:16] : rdWord[15:0];
	assign byteSel = rdWord[8*off +: 8];

	always_comb begin
		case (memOp)
			pipe_pkg::memLw: loadData = rdWord;
			pipe_pkg::memLh: loadData = {{(`PIPE_XLEN-16){halfSel[15]}}, halfSel};
			pipe_pkg::memLhu: loadData = {{(`PIPE_XLEN-16){1'b0}}, halfSel};
			pipe_pkg::memLb: loadData = {{(`PIPE_XLEN-8){byteSel[7]}}, byteSel};
			pipe_pkg::memLbu: loadData = {{(`PIPE_XLEN-8){1'b0}}, byteSel};
			default: loadData = '0;
		endcase
	end

endmodule

// ==== pipeCtrl.sv ====
`timescale 1ns/1ps

module pipeCtrl (
	input pipe_pkg::regIdxT rsD,
	input pipe_pkg::regIdxT rtD,
	input logic validD,
	input pipe_pkg::regIdxT destE,
	input logic loadE,
	input logic validE,
	input pipe_pkg::regIdxT rsE,
	input pipe_pkg::regIdxT rtE,
	input pipe_pkg::regIdxT destM,
	input logic writeM,
	input pipe_pkg::regIdxT destW,
	input logic writeW,
	output logic stallD,
	output logic bubbleE,
	output pipe_pkg::fwdSelE fwdA,
	output pipe_pkg::fwdSelE fwdB
);

	// producer writes a nonzero reg that the consumer reads
	function automatic logic hit(logic wr, pipe_pkg::regIdxT dst, pipe_pkg::regIdxT src);
		return wr && (dst != '0) && (dst == src);
	endfunction

	// load result only exists after memory, so hold one cycle
	assign stallD = validD && validE && (hit(loadE, destE, rsD) || hit(loadE, destE, rtD));
	assign bubbleE = stallD;

	// ============================================================
	// forwarding, youngest producer first
	// ============================================================
	always_comb begin
		if (hit(writeM, destM, rsE)) begin
			fwdA = pipe_pkg::fromMem;
		end else if (hit(writeW, destW, rsE)) begin
			fwdA = pipe_pkg::fromWb;
		end else begin
			fwdA = pipe_pkg::fromReg;
		end
		if (hit(writeM, destM, rtE)) begin
			fwdB = pipe_pkg::fromMem;
		end else if (hit(writeW, destW, rtE)) begin
			fwdB = pipe_pkg::fromWb;
		end else begin
			fwdB = pipe_pkg::fromReg;
		end
	end

endmodule

// ==== miniPipe.sv ====
`timescale 1ns/1ps

module miniPipe (
	input logic clk,
	input logic rst,
	input logic inValid,
	input pipe_pkg::wordT inInstr,
	output logic inReady,
	output logic retireValid,
	output pipe_pkg::retireT retire
);

	// decode stage
	logic validD;
	pipe_pkg::wordT instrD;
	pipe_pkg::ctrlBundleT ctrlD;
	pipe_pkg::regIdxT rsD, rtD, destD;
	pipe_pkg::wordT immD, rdA, rdB;
	logic [4:0] shamtD;
	pipe_pkg::exStageT exD;
	// execute stage
	logic validE;
	pipe_pkg::exStageT exQ;
	pipe_pkg::wordT opA, opB, aluB, aluRes;
	pipe_pkg::memStageT memE;
	// memory stage
	logic validM, writeM;
	pipe_pkg::memStageT memQ;
	pipe_pkg::wordT loadDataM;
	pipe_pkg::excCodeE alignExcM;
	pipe_pkg::retireT retM;
	// control
	logic stallD, bubbleE;
	pipe_pkg::fwdSelE fwdA, fwdB;

	function automatic pipe_pkg::wordT pickOperand(pipe_pkg::fwdSelE sel, pipe_pkg::wordT regVal,
		pipe_pkg::wordT memVal, pipe_pkg::wordT wbVal);
		case (sel)
			pipe_pkg::fromMem: return memVal;
			pipe_pkg::fromWb: return wbVal;
			default: return regVal;
		endcase
	endfunction

	// ============================================================
	// decode
	// ============================================================
	// stall holds decode and backs up the upstream handshake
	assign inReady = !stallD;

	stageReg #(.payloadT(pipe_pkg::wordT)) regD_i (
		.clk(clk), .rst(rst), .hold(stallD), .bubble(1'b0),
		.inValid(inValid), .inData(inInstr), .outValid(validD), .outData(instrD));

	instrDecode instrDecode_i (
		.instr(instrD), .ctrl(ctrlD), .rs(rsD), .rt(rtD), .dest(destD),
		.imm(immD), .shamt(shamtD));

	// written from the retire record
	regFile regFile_i (
		.clk(clk), .rst(rst), .wrEn(retireValid && retire.regWrite),
		.wrAddr(retire.dest), .wrData(retire.value),
		.rdAddrA(rsD), .rdAddrB(rtD), .rdDataA(rdA), .rdDataB(rdB));

	assign exD = '{ctrlD, rsD, rtD, destD, rdA, rdB, immD, shamtD};

	stageReg #(.payloadT(pipe_pkg::exStageT)) regE_i (
		.clk(clk), .rst(rst), .hold(1'b0), .bubble(bubbleE),
		.inValid(validD), .inData(exD), .outValid(validE), .outData(exQ));

	// ============================================================
	// execute
	// ============================================================
	assign opA = pickOperand(fwdA, exQ.opA, retM.value, retire.value);
	assign opB = pickOperand(fwdB, exQ.opB, retM.value, retire.value);
	assign aluB = exQ.ctrl.useImm ? exQ.imm : opB;

	aluUnit aluUnit_i (.op(exQ.ctrl.aluOp), .a(opA), .b(aluB), .shamt(exQ.shamt), .result(aluRes));

	// store data takes the forwarded rt value
	assign memE = '{exQ.ctrl, exQ.dest, aluRes, opB};

	stageReg #(.payloadT(pipe_pkg::memStageT)) regM_i (
		.clk(clk), .rst(rst), .hold(1'b0), .bubble(1'b0),
		.inValid(validE), .inData(memE), .outValid(validM), .outData(memQ));

	// ============================================================
	// memory
	// ============================================================
	memAccess memAccess_i (
		.clk(clk), .rst(rst), .valid(validM && memQ.ctrl.exc == pipe_pkg::excNone),
		.memOp(memQ.ctrl.memOp), .addr(memQ.aluRes), .storeData(memQ.storeData),
		.loadData(loadDataM), .alignExc(alignExcM));

	always_comb begin
		retM.dest = memQ.dest;
		retM.exc = (memQ.ctrl.exc != pipe_pkg::excNone) ? memQ.ctrl.exc : alignExcM;
		// any fault kills the register write
		retM.regWrite = memQ.ctrl.regWrite && (retM.exc == pipe_pkg::excNone);
		if (memQ.ctrl.exc == pipe_pkg::reservedInstr) begin
			retM.value = '0;
		end else if (pipe_pkg::isLoad(memQ.ctrl.memOp) && alignExcM == pipe_pkg::excNone) begin
			retM.value = loadDataM;
		end else begin
			// alu result, or effective address of a memory op
			retM.value = memQ.aluRes;
		end
	end

	assign writeM = validM && retM.regWrite;

	stageReg #(.payloadT(pipe_pkg::retireT)) regW_i (
		.clk(clk), .rst(rst), .hold(1'b0), .bubble(1'b0),
		.inValid(validM), .inData(retM), .outValid(retireValid), .outData(retire));

	// hazard and forwarding control
	pipeCtrl pipeCtrl_i (
		.rsD(rsD), .rtD(rtD), .validD(validD),
		.destE(exQ.dest), .loadE(pipe_pkg::isLoad(exQ.ctrl.memOp)), .validE(validE),
		.rsE(exQ.rs), .rtE(exQ.rt),
		.destM(memQ.dest), .writeM(writeM),
		.destW(retire.dest), .writeW(retireValid && retire.regWrite),
		.stallD(stallD), .bubbleE(bubbleE), .fwdA(fwdA), .fwdB(fwdB));

endmodule

// ==== tb_miniPipe.sv ====
`timescale 1ns/1ps
`include "pipe_settings.svh"

module tb_miniPipe;

	localparam int AcceptLimit = 100;
	localparam int DrainLimit = 200;

	logic clk;
	logic rst;
	logic inValid;
	pipe_pkg::wordT inInstr;
	logic inReady;
	logic retireValid;
	pipe_pkg::retireT retire;

	// reference state filled in acceptance order
	pipe_pkg::wordT mRegs [32];
	pipe_pkg::wordT mMem [`PIPE_DMEM_WORDS];
	pipe_pkg::retireT expQ [$];
	pipe_pkg::wordT instrQ [$];

	logic [15:0] lfsrState = 16'd5596;
	int checks = 0;
	int errors = 0;
	int lowSeen = 0;
	int testChecks = 0;
	int testErrors = 0;

	miniPipe miniPipe_i (
		.clk(clk), .rst(rst), .inValid(inValid), .inInstr(inInstr),
		.inReady(inReady), .retireValid(retireValid), .retire(retire));

	initial begin
		clk = 1'b0;
		forever #20 clk = ~clk;
	end

	// ============================================================
	// random source
	// ============================================================
	// galois form with taps 16 14 13 11
	function automatic logic [15:0] lfsrNext(input logic [15:0] s);
		if (s[0]) begin
			return (s >> 1) ^ 16'hB400;
		end
		return s >> 1;
	endfunction

	// one lfsr step per bit
	function automatic logic [31:0] randBits(input int n);
		logic [31:0] r;
		r = '0;
		for (int i = 0; i < n; i++) begin
			lfsrState = lfsrNext(lfsrState);
			r = {r[30:0], lfsrState[0]};
		end
		return r;
	endfunction

	function automatic logic [4:0] randNonZero();
		return 5'd1 + (randBits(5) % 31);
	endfunction

	// narrow picks r1..r3 only
	function automatic logic [4:0] randReg(input logic narrow);
		if (narrow) begin
			return 5'd1 + (randBits(2) % 3);
		end
		return randBits(5);
	endfunction

	// ============================================================
	// instruction builders
	// ============================================================
	function automatic pipe_pkg::wordT rType(input logic [5:0] fn, input logic [4:0] rd,
		input logic [4:0] rs, input logic [4:0] rt, input logic [4:0] sh);
		return {`PIPE_OP_RTYPE, rs, rt, rd, sh, fn};
	endfunction

	function automatic pipe_pkg::wordT iType(input logic [5:0] op, input logic [4:0] rt,
		input logic [4:0] rs, input logic [15:0] imm);
		return {op, rs, rt, imm};
	endfunction

	function automatic pipe_pkg::wordT randAlu(input logic narrow);
		int kind;
		logic [4:0] rd;
		logic [4:0] rs;
		logic [4:0] rt;
		logic [4:0] sh;
		logic [15:0] imm;
		kind = randBits(4) % 15;
		rd = randReg(narrow);
		rs = randReg(narrow);
		rt = randReg(narrow);
		sh = randBits(5);
		imm = randBits(16);
		case (kind)
			0: return rType(`PIPE_FN_ADDU, rd, rs, rt, 5'd0);
			1: return rType(`PIPE_FN_SUBU, rd, rs, rt, 5'd0);
			2: return rType(`PIPE_FN_AND, rd, rs, rt, 5'd0);
			3: return rType(`PIPE_FN_OR, rd, rs, rt, 5'd0);
			4: return rType(`PIPE_FN_XOR, rd, rs, rt, 5'd0);
			5: return rType(`PIPE_FN_NOR, rd, rs, rt, 5'd0);
			6: return rType(`PIPE_FN_SLT, rd, rs, rt, 5'd0);
			7: return rType(`PIPE_FN_SLTU, rd, rs, rt, 5'd0);
			8: return rType(`PIPE_FN_SLL, rd, 5'd0, rt, sh);
			9: return rType(`PIPE_FN_SRL, rd, 5'd0, rt, sh);
			10: return rType(`PIPE_FN_SRA, rd, 5'd0, rt, sh);
			11: return iType(`PIPE_OP_ADDIU, rt, rs, imm);
			12: return iType(`PIPE_OP_SLTI, rt, rs, imm);
			13: return iType(`PIPE_OP_ANDI, rt, rs, imm);
			default: return iType(`PIPE_OP_ORI, rt, rs, imm);
		endcase
	endfunction

	function automatic logic isKeptOp(input logic [5:0] op);
		return op inside {`PIPE_OP_RTYPE, `PIPE_OP_ADDIU, `PIPE_OP_SLTI, `PIPE_OP_ANDI,
			`PIPE_OP_ORI, `PIPE_OP_LB, `PIPE_OP_LH, `PIPE_OP_LW, `PIPE_OP_LBU, `PIPE_OP_LHU,
			`PIPE_OP_SB, `PIPE_OP_SH, `PIPE_OP_SW};
	endfunction

	function automatic logic isKeptFn(input logic [5:0] fn);
		return fn inside {`PIPE_FN_SLL, `PIPE_FN_SRL, `PIPE_FN_SRA, `PIPE_FN_ADDU,
			`PIPE_FN_SUBU, `PIPE_FN_AND, `PIPE_FN_OR, `PIPE_FN_XOR, `PIPE_FN_NOR,
			`PIPE_FN_SLT, `PIPE_FN_SLTU};
	endfunction

	// ============================================================
	// reference model steps one instruction at a time
	// ============================================================
	task automatic modelExec(input pipe_pkg::wordT instr);
		logic [5:0] op;
		logic [5:0] fn;
		logic [4:0] rs;
		logic [4:0] rt;
		logic [4:0] sh;
		logic [1:0] lane;
		pipe_pkg::wordT a;
		pipe_pkg::wordT b;
		pipe_pkg::wordT sImm;
		pipe_pkg::wordT addr;
		pipe_pkg::wordT word;
		pipe_pkg::wordT val;
		logic [15:0] half;
		logic [7:0] byteVal;
		int idx;
		pipe_pkg::retireT exp;
		op = instr[31:26];
		fn = instr[5:0];
		rs = instr[25:21];
		rt = instr[20:16];
		sh = instr[10:6];
		a = mRegs[rs];
		b = mRegs[rt];
		sImm = {{16{instr[15]}}, instr[15:0]};
		addr = a + sImm;
		idx = (addr >> 2) % `PIPE_DMEM_WORDS;
		lane = addr[1:0];
		word = mMem[idx];
		// little endian lanes
		half = lane[1] ? word[31:16] : word[15:0];
		byteVal = word >> (8 * lane);
		// r-type names rd and all else rt
		exp.dest = (op == `PIPE_OP_RTYPE) ? instr[15:11] : rt;
		exp.regWrite = 1'b0;
		exp.exc = pipe_pkg::excNone;
		val = '0;
		case (op)
			`PIPE_OP_RTYPE: begin
				exp.regWrite = 1'b1;
				case (fn)
					`PIPE_FN_ADDU: val = a + b;
					`PIPE_FN_SUBU: val = a - b;
					`PIPE_FN_AND: val = a & b;
					`PIPE_FN_OR: val = a | b;
					`PIPE_FN_XOR: val = a ^ b;
					`PIPE_FN_NOR: val = ~(a | b);
					`PIPE_FN_SLT: val = ($signed(a) < $signed(b)) ? 1 : 0;
					`PIPE_FN_SLTU: val = (a < b) ? 1 : 0;
					`PIPE_FN_SLL: val = b << sh;
					`PIPE_FN_SRL: val = b >> sh;
					`PIPE_FN_SRA: val = $signed(b) >>> sh;
					default: begin
						exp.regWrite = 1'b0;
						exp.exc = pipe_pkg::reservedInstr;
					end
				endcase
			end
			`PIPE_OP_ADDIU: begin
				exp.regWrite = 1'b1;
				val = a + sImm;
			end
			`PIPE_OP_SLTI: begin
				exp.regWrite = 1'b1;
				val = ($signed(a) < $signed(sImm)) ? 1 : 0;
			end
			`PIPE_OP_ANDI: begin
				exp.regWrite = 1'b1;
				val = a & {16'h0, instr[15:0]};
			end
			`PIPE_OP_ORI: begin
				exp.regWrite = 1'b1;
				val = a | {16'h0, instr[15:0]};
			end
			`PIPE_OP_LW, `PIPE_OP_LH, `PIPE_OP_LHU, `PIPE_OP_LB, `PIPE_OP_LBU: begin
				if ((op == `PIPE_OP_LW && lane != 2'b00) ||
					((op == `PIPE_OP_LH || op == `PIPE_OP_LHU) && lane[0])) begin
					exp.exc = pipe_pkg::loadAddrErr;
					val = addr;
				end else begin
					exp.regWrite = 1'b1;
					case (op)
						`PIPE_OP_LW: val = word;
						`PIPE_OP_LH: val = {{16{half[15]}}, half};
						`PIPE_OP_LHU: val = {16'h0, half};
						`PIPE_OP_LB: val = {{24{byteVal[7]}}, byteVal};
						default: val = {24'h0, byteVal};
					endcase
				end
			end
			`PIPE_OP_SW, `PIPE_OP_SH, `PIPE_OP_SB: begin
				val = addr;
				if ((op == `PIPE_OP_SW && lane != 2'b00) || (op == `PIPE_OP_SH && lane[0])) begin
					exp.exc = pipe_pkg::storeAddrErr;
				end else begin
					case (op)
						`PIPE_OP_SW: word = b;
						`PIPE_OP_SH: word[16*lane[1] +: 16] = b[15:0];
						default: word[8*lane +: 8] = b[7:0];
					endcase
					mMem[idx] = word;
				end
			end
			default: exp.exc = pipe_pkg::reservedInstr;
		endcase
		exp.value = val;
		if (exp.regWrite && exp.dest != 5'd0) begin
			mRegs[exp.dest] = val;
		end
		expQ.push_back(exp);
		instrQ.push_back(instr);
	endtask

	// ============================================================
	// checking and run control
	// ============================================================
	task automatic checkVal(input logic [63:0] got, input logic [63:0] expected,
		input string msg);
		checks++;
		if (got !== expected) begin
			errors++;
			$display("CHECK FAILED at %0t ns: %s, got %h, expected %h", $time, msg, got,
				expected);
		end
	endtask

	task automatic finishRun();
		$display("summary: %0d checks, %0d errors", checks, errors);
		if (errors == 0) begin
			$display("ALL TESTS PASSED");
		end else begin
			$display("SOME TESTS FAILED");
		end
		$finish;
	endtask

	// entered and left on a falling edge
	task automatic sendInstr(input pipe_pkg::wordT instr, input logic allowGap);
		int waited;
		if (allowGap && randBits(2) == 0) begin
			inValid = 1'b0;
			@(negedge clk);
		end
		inValid = 1'b1;
		inInstr = instr;
		waited = 0;
		// inReady only moves on the rising edge
		while (!inReady && waited < AcceptLimit) begin
			@(negedge clk);
			waited++;
		end
		if (!inReady) begin
			$display("timeout: instruction %h was not accepted within %0d cycles", instr, waited);
			errors++;
			finishRun();
		end else begin
			modelExec(instr);
			@(negedge clk);
			inValid = 1'b0;
		end
	endtask

	task automatic finishTest(input int num, input string name);
		int waited;
		waited = 0;
		while (expQ.size() != 0 && waited < DrainLimit) begin
			@(negedge clk);
			waited++;
		end
		if (expQ.size() != 0) begin
			$display("timeout: %0d instructions never retired in test %0d", expQ.size(), num);
			errors++;
			finishRun();
		end else begin
			$display("test %0d %s: %0d checks, %0d errors", num, name, checks - testChecks,
				errors - testErrors);
			testChecks = checks;
			testErrors = errors;
		end
	endtask

	// retire monitor samples between edges
	initial begin
		pipe_pkg::retireT expRec;
		pipe_pkg::wordT expInstr;
		forever begin
			@(negedge clk);
			if (!rst) begin
				if (!inReady) begin
					lowSeen++;
				end
				if (retireValid) begin
					if (expQ.size() == 0) begin
						$display("unexpected retire at %0t ns with nothing outstanding", $time);
						errors++;
					end else begin
						expRec = expQ.pop_front();
						expInstr = instrQ.pop_front();
						checkVal(retire, expRec, $sformatf("retire of instr %h", expInstr));
					end
				end
			end
		end
	end

	// ============================================================
	// test sequence
	// ============================================================
	initial begin
		logic [15:0] off;
		logic [4:0] dst;
		logic [5:0] op;
		logic [5:0] fn;
		logic [1:0] kind;
		logic [31:0] fields;
		pipe_pkg::wordT instr;
		rst = 1'b1;
		inValid = 1'b0;
		inInstr = '0;
		for (int r = 0; r < 32; r++) begin
			mRegs[r] = '0;
		end
		for (int w = 0; w < `PIPE_DMEM_WORDS; w++) begin
			mMem[w] = '0;
		end
		repeat (16) @(posedge clk);
		@(negedge clk);
		rst = 1'b0;

		// seed every register then run random ops incl. r0 targets
		for (int r = 1; r < 32; r++) begin
			sendInstr(iType(`PIPE_OP_ADDIU, r, 5'd0, randBits(16)), 1'b1);
		end
		for (int i = 0; i < 60; i++) begin
			sendInstr(randAlu(1'b0), 1'b1);
			// r0 must read back as zero
			if (i % 15 == 0) begin
				sendInstr(rType(`PIPE_FN_OR, randNonZero(), 5'd0, 5'd0, 5'd0), 1'b1);
			end
		end
		finishTest(1, "random alu");

		// tight chains forward from memory and writeback
		for (int i = 0; i < 60; i++) begin
			sendInstr(randAlu(1'b1), 1'b1);
		end
		finishTest(2, "forwarding chains");

		// load then an immediate user
		lowSeen = 0;
		for (int i = 0; i < 12; i++) begin
			off = randBits(6) << 2;
			sendInstr(iType(`PIPE_OP_SW, randNonZero(), 5'd0, off), 1'b1);
			kind = randBits(2);
			dst = randNonZero();
			case (kind)
				2'd0: instr = iType(`PIPE_OP_LW, dst, 5'd0, off);
				2'd1: instr = iType(`PIPE_OP_LH, dst, 5'd0, off + (randBits(1) << 1));
				2'd2: instr = iType(`PIPE_OP_LBU, dst, 5'd0, off + randBits(2));
				default: instr = iType(`PIPE_OP_LB, dst, 5'd0, off + randBits(2));
			endcase
			sendInstr(instr, 1'b1);
			if (randBits(1)) begin
				sendInstr(rType(`PIPE_FN_ADDU, randNonZero(), dst, randNonZero(), 5'd0), 1'b0);
			end else begin
				// store data path through rt
				sendInstr(iType(`PIPE_OP_SW, dst, 5'd0, off ^ 16'h0040), 1'b0);
			end
		end
		if (lowSeen == 0) begin
			$display("inReady never went low during the load-use test");
			errors++;
		end
		finishTest(3, "load use");

		// each store width followed by every load kind over the word
		for (int round = 0; round < 2; round++) begin
			for (int w = 0; w < 3; w++) begin
				off = randBits(6) << 2;
				case (w)
					0: instr = iType(`PIPE_OP_SW, randNonZero(), 5'd0, off);
					1: instr = iType(`PIPE_OP_SH, randNonZero(), 5'd0, off + (randBits(1) << 1));
					default: instr = iType(`PIPE_OP_SB, randNonZero(), 5'd0, off + randBits(2));
				endcase
				sendInstr(instr, 1'b1);
				sendInstr(iType(`PIPE_OP_LW, randNonZero(), 5'd0, off), 1'b1);
				for (int k = 0; k < 4; k += 2) begin
					sendInstr(iType(`PIPE_OP_LH, randNonZero(), 5'd0, off + k), 1'b1);
					sendInstr(iType(`PIPE_OP_LHU, randNonZero(), 5'd0, off + k), 1'b1);
				end
				for (int k = 0; k < 4; k++) begin
					sendInstr(iType(`PIPE_OP_LB, randNonZero(), 5'd0, off + k), 1'b1);
					sendInstr(iType(`PIPE_OP_LBU, randNonZero(), 5'd0, off + k), 1'b1);
				end
			end
		end
		finishTest(4, "store load widths");

		// misaligned access followed by word and register readback
		for (int i = 0; i < 10; i++) begin
			off = randBits(6) << 2;
			dst = randNonZero();
			case (randBits(3) % 5)
				0: instr = iType(`PIPE_OP_LW, dst, 5'd0, off + 1 + (randBits(2) % 3));
				1: instr = iType(`PIPE_OP_LH, dst, 5'd0, off + (randBits(1) ? 1 : 3));
				2: instr = iType(`PIPE_OP_LHU, dst, 5'd0, off + (randBits(1) ? 1 : 3));
				3: instr = iType(`PIPE_OP_SW, dst, 5'd0, off + 1 + (randBits(2) % 3));
				default: instr = iType(`PIPE_OP_SH, dst, 5'd0, off + (randBits(1) ? 1 : 3));
			endcase
			sendInstr(instr, 1'b1);
			sendInstr(iType(`PIPE_OP_LW, randNonZero(), 5'd0, off), 1'b1);
			sendInstr(rType(`PIPE_FN_OR, randNonZero(), dst, 5'd0, 5'd0), 1'b1);
		end
		finishTest(5, "misaligned access");

		// unused opcode or unused r-type funct
		for (int i = 0; i < 20; i++) begin
			op = randBits(6);
			fields = randBits(26);
			if (isKeptOp(op)) begin
				fn = randBits(6);
				while (isKeptFn(fn)) begin
					fn = randBits(6);
				end
				instr = {`PIPE_OP_RTYPE, fields[19:0], fn};
			end else begin
				instr = {op, fields[25:0]};
			end
			sendInstr(instr, 1'b1);
			// read back the register the reserved instr names as its target
			dst = (instr[31:26] == `PIPE_OP_RTYPE) ? instr[15:11] : instr[20:16];
			sendInstr(rType(`PIPE_FN_OR, randNonZero(), dst, 5'd0, 5'd0), 1'b1);
		end
		finishTest(6, "reserved instr");

		finishRun();
	end

endmodule

// ==== filelist.f ====
+incdir+.
pipe_pkg.sv
stageReg.sv
instrDecode.sv
regFile.sv
aluUnit.sv
memAccess.sv
pipeCtrl.sv
miniPipe.sv
tb_miniPipe.sv

// ==== Bender.yml ====
package:
  name: mini_pipe

sources:
  - include_dirs:
      - .
    files:
      - pipe_pkg.sv
      - stageReg.sv
      - instrDecode.sv
      - regFile.sv
      - aluUnit.sv
      - memAccess.sv
      - pipeCtrl.sv
      - miniPipe.sv
  - target: test
    include_dirs:
      - .
    files:
      - tb_miniPipe.sv
